// ==== source/tile_mem_pkg.sv ====
// Tile memory package with shared data widths, block geometry and sizing helpers
package tile_mem_pkg;

   // Width of one data word
   localparam int data_w = 32;

   // Byte selects per word
   localparam int sel_w = 4;

   // Bits per byte lane
   localparam int byte_w = data_w / sel_w;

   // Byte address on the request port
   localparam int addr_w = 32;

   // One block RAM holds 512 words of 32 bits
   localparam int block_words = 512;

   // Word index inside a block
   localparam int block_aw = 9;

   // 16 kByte by default, which is 8 blocks
   localparam int mem_size_default = 16384;

   // Response queue entries
   localparam int resp_depth_default = 4;

   // Word address width for a memory of mem_size bytes
   function automatic int word_addr_w(input int mem_size);
      int words;
      words = mem_size / 4;
      return (words > 1) ? $clog2(words) : 1;
   endfunction

   // Counter width able to hold 0 up to depth
   function automatic int count_w(input int depth);
      return $clog2(depth + 1);
   endfunction

endpackage

// ==== source/sram_block.sv ====
// Behavioral block RAM, 512 words of 32 bits with byte write enables and registered read
`timescale 1ns/1ns

module sram_block (
   input  logic                                clk,
   // Port enable, one access per cycle
   input  logic                                ce,
   input  logic                                we,
   // One bit per byte lane
   input  logic [tile_mem_pkg::sel_w-1:0]      sel,
   // Word inside the block
   input  logic [tile_mem_pkg::block_aw-1:0]   addr,
   input  logic [tile_mem_pkg::data_w-1:0]     din,
   output logic [tile_mem_pkg::data_w-1:0]     dout
);

   // Word storage
   logic [tile_mem_pkg::data_w-1:0] mem [tile_mem_pkg::block_words];

   // Masked write
   // Only lanes with sel set are touched
   always_ff @(posedge clk) begin
      if (ce && we) begin
         for (int b = 0; b < tile_mem_pkg::sel_w; b++) begin
            if (sel[b]) begin
               mem[addr][tile_mem_pkg::byte_w*b +: tile_mem_pkg::byte_w] <=
                  din[tile_mem_pkg::byte_w*b +: tile_mem_pkg::byte_w];
            end
         end
      end
   end

   // Registered read port
   // Read-first, so a write cycle returns the old word
   // Output holds its value while the port is idle
   always_ff @(posedge clk) begin
      if (ce) begin
         dout <= mem[addr];
      end
   end

endmodule

// ==== source/sram_sp_impl.sv ====
// Single-port word memory of configurable size built from 512-word block RAMs
`timescale 1ns/1ns

module sram_sp_impl #(
   // Memory size in bytes, multiple of 4
   parameter int MEM_SIZE = tile_mem_pkg::mem_size_default
) (
   input  logic                                               clk,
   input  logic                                               rst,
   input  logic                                               ce,
   input  logic                                               we,
   input  logic [tile_mem_pkg::sel_w-1:0]                     sel,
   // Word address
   input  logic [tile_mem_pkg::word_addr_w(MEM_SIZE)-1:0]     addr,
   input  logic [tile_mem_pkg::data_w-1:0]                    din,
   // Valid one cycle after ce
   output logic [tile_mem_pkg::data_w-1:0]                    dout
);

   // Memory size in words
   localparam int mem_words = MEM_SIZE / 4;
   localparam int aw = tile_mem_pkg::word_addr_w(MEM_SIZE);
   localparam int waw = tile_mem_pkg::block_aw;

   // Number of blocks, rounded up
   // A partly used last block is allowed
   localparam int block_num =
      (mem_words + tile_mem_pkg::block_words - 1) / tile_mem_pkg::block_words;

   // Block index width, at least one bit
   localparam int bw = (block_num > 1) ? $clog2(block_num) : 1;

   // Address split
   //   | block | word in block |
   logic [aw+waw-1:0]                 addr_ext;
   logic [waw-1:0]                    word_idx;
   logic [bw-1:0]                     block_idx;
   // Block of the last access, for the read mux
   logic [bw-1:0]                     block_idx_q;
   logic [tile_mem_pkg::data_w-1:0]   block_dout [block_num];

   // Zero extend so small memories still give a full word index
   assign addr_ext  = {{waw{1'b0}}, addr};
   assign word_idx  = addr_ext[waw-1:0];
   assign block_idx = addr_ext[waw +: bw];

   // One block RAM per 512 words
   for (genvar i = 0; i < block_num; i++) begin : g_block
      logic blk_ce;

      // Enable only the addressed block
      assign blk_ce = ce & (block_idx == i);

      sram_block u_block (
         .clk  (clk),
         .ce   (blk_ce),
         .we   (we),
         .sel  (sel),
         .addr (word_idx),
         .din  (din),
         .dout (block_dout[i])
      );
   end

   // Block select follows the block read latency
   always_ff @(posedge clk) begin
      if (rst) begin
         block_idx_q <= '0;
      end else if (ce) begin
         block_idx_q <= block_idx;
      end
   end

   // Read mux
   assign dout = block_dout[block_idx_q];

endmodule

// ==== source/mem_req_frontend.sv ====
// Request front end, range check, memory access and response queue reservation
`timescale 1ns/1ns

module mem_req_frontend #(
   // Memory size in bytes
   parameter int MEM_SIZE   = tile_mem_pkg::mem_size_default,
   // Response queue entries
   parameter int RESP_DEPTH = tile_mem_pkg::resp_depth_default
) (
   input  logic                                               clk,
   input  logic                                               rst,

   // Request channel
   input  logic                                               req_valid,
   output logic                                               req_ready,
   input  logic [tile_mem_pkg::addr_w-1:0]                    req_addr,
   input  logic                                               req_we,
   input  logic [tile_mem_pkg::sel_w-1:0]                     req_sel,
   input  logic [tile_mem_pkg::data_w-1:0]                    req_wdata,

   // Memory port
   output logic                                               ce,
   output logic                                               we,
   output logic [tile_mem_pkg::sel_w-1:0]                     sel,
   output logic [tile_mem_pkg::word_addr_w(MEM_SIZE)-1:0]     addr,
   output logic [tile_mem_pkg::data_w-1:0]                    din,

   // Response queue side
   input  logic [tile_mem_pkg::count_w(RESP_DEPTH)-1:0]       space,
   output logic                                               push,
   output logic                                               push_read,
   output logic                                               push_err
);

   localparam int aw = tile_mem_pkg::word_addr_w(MEM_SIZE);
   localparam int cw = tile_mem_pkg::count_w(RESP_DEPTH);

   // Handshake done this cycle
   logic          accept;
   // Address below MEM_SIZE
   logic          in_range;
   // Entry claimed but not yet in the queue
   logic [cw-1:0] resv;

   // Push is high for exactly the cycle between acceptance and the queue write
   // so it doubles as the in-flight reservation
   assign resv = cw'(push);

   // Need one free entry after the pending push lands
   assign req_ready = (space > resv);

   assign accept = req_valid & req_ready;

   // Byte address compare
   // Low two bits do not matter since MEM_SIZE is word aligned
   assign in_range = (req_addr < MEM_SIZE);

   // Memory access only for good addresses
   assign ce   = accept & in_range;
   assign we   = req_we;
   assign sel  = req_sel;
   assign din  = req_wdata;
   // Word address, byte offset dropped
   assign addr = req_addr[aw+1:2];

   // Push lines up with the memory read data
   always_ff @(posedge clk) begin
      if (rst) begin
         push <= 1'b0;
      end else begin
         push <= accept;
      end
   end

   // Response kind of the accepted request
   always_ff @(posedge clk) begin
      if (accept) begin
         // Read data only for in-range reads
         push_read <= ~req_we & in_range;
         push_err  <= ~in_range;
      end
   end

endmodule

// ==== source/mem_resp_fifo.sv ====
// In-order response queue with free entry count and valid/ready output
`timescale 1ns/1ns

module mem_resp_fifo #(
   // Number of entries
   parameter int RESP_DEPTH = tile_mem_pkg::resp_depth_default
) (
   input  logic                                          clk,
   input  logic                                          rst,

   // From the front end
   input  logic                                          push,
   input  logic                                          push_read,
   input  logic                                          push_err,
   // Memory read data, valid with push
   input  logic [tile_mem_pkg::data_w-1:0]               mem_rdata,
   // Free entries
   output logic [tile_mem_pkg::count_w(RESP_DEPTH)-1:0]  space,

   // Response channel
   output logic                                          resp_valid,
   input  logic                                          resp_ready,
   output logic [tile_mem_pkg::data_w-1:0]               resp_rdata,
   output logic                                          resp_err
);

   localparam int cw = tile_mem_pkg::count_w(RESP_DEPTH);
   localparam int pw = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
   localparam logic [cw-1:0] depth_c = cw'(RESP_DEPTH);
   // Pointer value before wrap
   localparam logic [pw-1:0] last_c = pw'(RESP_DEPTH - 1);

   // Entry storage
   logic [tile_mem_pkg::data_w-1:0] data_q [RESP_DEPTH];
   logic                            err_q  [RESP_DEPTH];

   logic [pw-1:0] wr_ptr;
   logic [pw-1:0] rd_ptr;
   // Occupied entries
   logic [cw-1:0] count;
   logic          pop;

   assign pop = resp_valid & resp_ready;

   // Head entry straight from the storage flops
   assign resp_valid = (count != '0);
   assign resp_rdata = data_q[rd_ptr];
   assign resp_err   = err_q[rd_ptr];

   assign space = depth_c - count;

   // Writes and errors carry zero data
   always_ff @(posedge clk) begin
      if (push) begin
         data_q[wr_ptr] <= push_read ? mem_rdata : '0;
         err_q[wr_ptr]  <= push_err;
      end
   end

   // Pointers wrap at RESP_DEPTH
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == last_c) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == last_c) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // Count, push and pop may coincide
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== source/tile_mem.sv ====
// Local tile memory top, request front end, block memory and response queue
`timescale 1ns/1ns

module tile_mem #(
   // Memory size in bytes, multiple of 4
   parameter int MEM_SIZE   = tile_mem_pkg::mem_size_default,
   // Response queue entries
   parameter int RESP_DEPTH = tile_mem_pkg::resp_depth_default
) (
   input  logic                                clk,
   input  logic                                rst,

   // Request channel
   input  logic                                req_valid,
   output logic                                req_ready,
   input  logic [tile_mem_pkg::addr_w-1:0]     req_addr,
   input  logic                                req_we,
   input  logic [tile_mem_pkg::sel_w-1:0]      req_sel,
   input  logic [tile_mem_pkg::data_w-1:0]     req_wdata,

   // Response channel
   output logic                                resp_valid,
   input  logic                                resp_ready,
   output logic [tile_mem_pkg::data_w-1:0]     resp_rdata,
   output logic                                resp_err
);

   localparam int aw = tile_mem_pkg::word_addr_w(MEM_SIZE);
   localparam int cw = tile_mem_pkg::count_w(RESP_DEPTH);

   // Front end to memory
   logic                            mem_ce;
   logic                            mem_we;
   logic [tile_mem_pkg::sel_w-1:0]  mem_sel;
   logic [aw-1:0]                   mem_addr;
   logic [tile_mem_pkg::data_w-1:0] mem_din;
   // Memory to queue
   logic [tile_mem_pkg::data_w-1:0] mem_dout;

   // Front end and queue
   logic [cw-1:0]                   space;
   logic                            push;
   logic                            push_read;
   logic                            push_err;

   // Request side
   mem_req_frontend #(
      .MEM_SIZE   (MEM_SIZE),
      .RESP_DEPTH (RESP_DEPTH)
   ) u_frontend (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_addr   (req_addr),
      .req_we     (req_we),
      .req_sel    (req_sel),
      .req_wdata  (req_wdata),
      .ce         (mem_ce),
      .we         (mem_we),
      .sel        (mem_sel),
      .addr       (mem_addr),
      .din        (mem_din),
      .space      (space),
      .push       (push),
      .push_read  (push_read),
      .push_err   (push_err)
   );

   // Storage
   sram_sp_impl #(
      .MEM_SIZE (MEM_SIZE)
   ) u_mem (
      .clk  (clk),
      .rst  (rst),
      .ce   (mem_ce),
      .we   (mem_we),
      .sel  (mem_sel),
      .addr (mem_addr),
      .din  (mem_din),
      .dout (mem_dout)
   );

   // Response side
   mem_resp_fifo #(
      .RESP_DEPTH (RESP_DEPTH)
   ) u_resp_fifo (
      .clk        (clk),
      .rst        (rst),
      .push       (push),
      .push_read  (push_read),
      .push_err   (push_err),
      .mem_rdata  (mem_dout),
      .space      (space),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_rdata (resp_rdata),
      .resp_err   (resp_err)
   );

endmodule

// ==== verif/tile_mem_tb.sv ====
// Testbench for the tile memory checking random requests against a reference word model
`timescale 1ns/1ns

module tile_mem_tb;

   localparam int mem_size   = 16384;
   localparam int resp_depth = 4;
   localparam int mem_words  = mem_size / 4;
   localparam int wbits      = $clog2(mem_words);
   localparam int dw         = tile_mem_pkg::data_w;
   localparam int sw         = tile_mem_pkg::sel_w;
   localparam int bw         = tile_mem_pkg::byte_w;
   // Requests over all tests for the watchdog limit
   localparam int total_reqs = 64 + 96 + 64 + (resp_depth + 2) + 600;

   logic                            clk = 1'b0;
   logic                            rst = 1'b1;
   logic                            req_valid = 1'b0;
   logic                            req_ready;
   logic [tile_mem_pkg::addr_w-1:0] req_addr = '0;
   logic                            req_we = 1'b0;
   logic [sw-1:0]                   req_sel = '0;
   logic [dw-1:0]                   req_wdata = '0;
   logic                            resp_valid;
   logic                            resp_ready = 1'b1;
   logic [dw-1:0]                   resp_rdata;
   logic                            resp_err;

   // Reference words and the bits written so far
   logic [dw-1:0] ref_mem   [mem_words];
   logic [dw-1:0] ref_known [mem_words];
   // Expected responses with the oldest first
   logic [dw-1:0] exp_data  [$];
   logic [dw-1:0] exp_known [$];
   logic          exp_err   [$];

   logic [31:0] lfsr = 32'h9509c948;
   int          errors = 0;
   int          n_failed = 0;
   int          acc_count = 0;
   int          acc_start = 0;
   // 0 always ready, 1 random stalls, 2 held low
   int          resp_mode = 0;

   tile_mem #(
      .MEM_SIZE   (mem_size),
      .RESP_DEPTH (resp_depth)
   ) tile_mem_inst (.*);

   always #5 clk = ~clk;

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return v;
   endfunction

   // Byte address of a word with a random byte offset
   function automatic logic [31:0] word_addr(input int word);
      return (32'(word) << 2) | rand_bits(2);
   endfunction

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Holds the request stable until the DUT takes it
   task automatic send_req(input logic [31:0] addr, input logic we,
                           input logic [sw-1:0] sel, input logic [dw-1:0] wdata);
      logic taken;
      req_valid = 1'b1;
      req_addr  = addr;
      req_we    = we;
      req_sel   = sel;
      req_wdata = wdata;
      taken     = 1'b0;
      while (!taken) begin
         // req_ready is driven from flops and settles well before the falling edge
         @(negedge clk);
         taken = req_ready;
         @(posedge clk);
         #1;
      end
      req_valid = 1'b0;
   endtask

   // Bytes never written are masked out
   task automatic compare_data(input string name, input logic [dw-1:0] got,
                               input logic [dw-1:0] exp, input logic [dw-1:0] known);
      if ((got & known) !== (exp & known)) begin
         $display("MISMATCH %s got %h expected %h", name, got & known, exp & known);
         errors++;
      end
   endtask

   task automatic compare_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      if (errors == err_start) begin
         $display("test %s: PASS", name);
      end else begin
         n_failed++;
         $display("test %s: FAIL, %0d errors", name, errors - err_start);
      end
   endtask

   // Checks and predictions
   // Sampled at the falling edge before the transfer edge
   always @(negedge clk) begin : monitor
      int idx;
      int held;
      if (!rst && resp_valid && resp_ready) begin
         if (exp_err.size() == 0) begin
            $display("response arrived with no request outstanding");
            errors++;
         end else begin
            compare_data("resp_rdata", resp_rdata, exp_data.pop_front(), exp_known.pop_front());
            compare_err("resp_err", resp_err, exp_err.pop_front());
         end
      end
      if (!rst && req_valid && req_ready) begin
         acc_count++;
         idx = int'(req_addr[wbits+1:2]);
         exp_err.push_back(req_addr >= mem_size);
         // Writes and errors answer with zero
         if (req_addr >= mem_size || req_we) begin
            exp_data.push_back('0);
            exp_known.push_back('1);
         end else begin
            exp_data.push_back(ref_mem[idx]);
            exp_known.push_back(ref_known[idx]);
         end
         if (req_addr < mem_size && req_we) begin
            for (int b = 0; b < sw; b++) begin
               if (req_sel[b]) begin
                  ref_mem[idx][bw*b +: bw]   = req_wdata[bw*b +: bw];
                  ref_known[idx][bw*b +: bw] = '1;
               end
            end
         end
      end
      // Queue full with resp_ready low
      if (resp_mode == 2 && req_valid && !req_ready) begin
         held = acc_count - acc_start;
         if (held > resp_depth) begin
            $display("req_ready fell only after %0d requests were held back", held);
            errors++;
         end
         resp_mode = 0;
      end
   end

   // Response acceptance
   always @(posedge clk) begin : resp_drive
      logic nxt;
      nxt = (resp_mode == 1) ? (rand_bits(2) != 0) : (resp_mode == 0);
      #1;
      resp_ready = nxt;
   end

   // Kinds
   //   0 write and read back in every block, 1 byte selects, 2 out of range
   //   3 response back-pressure, 4 random mixed stream
   task automatic run_test(input string name, input int kind, input int n);
      int            err_start;
      int            k;
      logic [31:0]   base;
      logic [31:0]   addr;
      logic          we;
      logic [sw-1:0] sel;
      err_start = errors;
      base      = '0;
      resp_mode = (kind == 4) ? 1 : ((kind == 3) ? 2 : 0);
      if (kind == 3) begin
         // resp_ready low before the first request
         idle(2);
         acc_start = acc_count;
      end
      for (int i = 0; i < n; i++) begin
         sel = '1;
         case (kind)
            0: begin
               // Write then read four words per block
               k = i % 2;
               base = (k == 0) ? word_addr((i / 8) * tile_mem_pkg::block_words +
                                           int'(rand_bits(tile_mem_pkg::block_aw))) : base;
               we   = (k == 0);
               addr = base;
            end
            1: begin
               // Full write, partial write, merged read
               k = i % 3;
               base = (k == 0) ? word_addr(int'(rand_bits(wbits))) : base;
               sel  = (k == 1) ? rand_bits(sw) : sel;
               we   = (k != 2);
               addr = base;
            end
            2: begin
               // In-range write, aliased write and read above MEM_SIZE, read back
               k = i % 4;
               base = (k == 0) ? word_addr(int'(rand_bits(wbits))) : base;
               we   = (k < 2);
               addr = (k == 1 || k == 2) ?
                      (base | (rand_bits(18) << (wbits + 2)) | 32'(mem_size)) : base;
            end
            default: begin
               if (kind == 4 && rand_bits(2) == 0) begin
                  idle(int'(rand_bits(2)) + 1);
               end
               we  = rand_bits(1);
               sel = rand_bits(sw);
               // Small window across all blocks so reads hit written words
               k    = int'(rand_bits(6));
               addr = word_addr(((k >> 3) << tile_mem_pkg::block_aw) | (k & 7));
               addr = (rand_bits(4) == 0) ? (rand_bits(32) | 32'(mem_size)) : addr;
            end
         endcase
         send_req(addr, we, sel, rand_bits(dw));
      end
      if (resp_mode == 2) begin
         $display("req_ready stayed high while responses were held back");
         errors++;
      end
      resp_mode = 0;
      while (exp_err.size() != 0) begin
         @(posedge clk);
      end
      idle(1);
      report_test(name, err_start);
   endtask

   initial begin
      for (int i = 0; i < mem_words; i++) begin
         ref_known[i] = '0;
      end
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      // Nothing may come back while idle after reset
      repeat (8) begin
         @(negedge clk);
         if (resp_valid !== 1'b0) begin
            $display("MISMATCH resp_valid got %h expected 0", resp_valid);
            errors++;
         end
         if (req_ready !== 1'b1) begin
            $display("MISMATCH req_ready got %h expected 1", req_ready);
            errors++;
         end
      end
      @(posedge clk);
      #1;
      report_test("reset_idle", 0);
      run_test("write_read", 0, 64);
      run_test("byte_select", 1, 96);
      run_test("out_of_range", 2, 64);
      run_test("backpressure", 3, resp_depth + 2);
      run_test("random_stream", 4, 600);
      $display("6 tests, %0d failed, %0d errors", n_failed, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog allows 40 cycles per request plus reset
   initial begin
      repeat (10 + 40 * total_reqs) @(posedge clk);
      $display("timeout, tests still running after %0d cycles", 10 + 40 * total_reqs);
      $display("Verification failed");
      $finish;
   end

endmodule

// ==== src.f ====
source/tile_mem_pkg.sv
source/sram_block.sv
source/sram_sp_impl.sv
source/mem_req_frontend.sv
source/mem_resp_fifo.sv
source/tile_mem.sv
verif/tile_mem_tb.sv
